//--- design/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    input  alu_pkg::alu_op_t         op,
    output logic [alu_pkg::xlen-1:0] result
);
    import alu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // upper bits ignored

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- design/alu_pkg.sv
package alu_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_reg,
        src_a_pc,
        src_a_zero // lui
    } src_a_sel_t;

    typedef enum logic {
        src_b_reg,
        src_b_imm
    } src_b_sel_t;

    typedef enum logic {
        wb_alu,
        wb_snpc // link address of jal and jalr
    } wb_sel_t;

endpackage

//--- design/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  isa_pkg::rv_inst_u   inst,
    output isa_pkg::reg_addr_t  rs1,
    output isa_pkg::reg_addr_t  rs2,
    output isa_pkg::reg_addr_t  rd,
    output logic [31:0]         imm,
    output alu_pkg::alu_op_t    alu_op,
    output alu_pkg::src_a_sel_t src_a_sel,
    output alu_pkg::src_b_sel_t src_b_sel,
    output alu_pkg::wb_sel_t    wb_sel,
    output logic                rd_write,
    output logic                is_branch,
    output logic                is_jal,
    output logic                is_jalr,
    output logic [2:0]          branch_funct,
    output logic                illegal
);
    import isa_pkg::*;
    import alu_pkg::*;

    inst_fmt_t fmt;
    alu_op_t   funct_op;

    always_comb begin
        case (inst.r.opcode)
            op_reg:           fmt = fmt_r;
            op_imm, op_jalr:  fmt = fmt_i;
            op_lui, op_auipc: fmt = fmt_u;
            op_jal:           fmt = fmt_j;
            op_branch:        fmt = fmt_b;
            default:          fmt = fmt_none;
        endcase
    end

    // register fields only where the format carries them
    always_comb begin
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        case (fmt)
            fmt_r: begin
                rs1 = inst.r.rs1;
                rs2 = inst.r.rs2;
                rd  = inst.r.rd;
            end
            fmt_i: begin
                rs1 = inst.i.rs1;
                rd  = inst.i.rd;
            end
            fmt_b: begin
                rs1 = inst.b.rs1;
                rs2 = inst.b.rs2;
            end
            fmt_u:   rd = inst.u.rd;
            fmt_j:   rd = inst.j.rd;
            default: ;
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i:   imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            fmt_b:   imm = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                            inst.b.imm_4_1, 1'b0};
            fmt_u:   imm = {inst.u.imm_31_12, 12'b0};
            fmt_j:   imm = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                            inst.j.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // funct7 bit 5 picks sub (R type only) and sra
    always_comb begin
        case (inst.r.funct3)
            f3_add:  funct_op = (fmt == fmt_r && inst.r.funct7[5]) ? alu_sub : alu_add;
            f3_sll:  funct_op = alu_sll;
            f3_slt:  funct_op = alu_slt;
            f3_sltu: funct_op = alu_sltu;
            f3_xor:  funct_op = alu_xor;
            f3_sr:   funct_op = inst.r.funct7[5] ? alu_sra : alu_srl;
            f3_or:   funct_op = alu_or;
            default: funct_op = alu_and;
        endcase
    end

    assign branch_funct = inst.b.funct3;

    always_comb begin
        alu_op    = alu_add;
        src_a_sel = src_a_reg;
        src_b_sel = src_b_imm;
        wb_sel    = wb_alu;
        rd_write  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        illegal   = 1'b0;
        case (inst.r.opcode)
            op_reg: begin
                alu_op    = funct_op;
                src_b_sel = src_b_reg;
                rd_write  = 1'b1;
            end
            op_imm: begin
                alu_op   = funct_op;
                rd_write = 1'b1;
            end
            op_lui: begin
                src_a_sel = src_a_zero;
                rd_write  = 1'b1;
            end
            op_auipc: begin
                src_a_sel = src_a_pc;
                rd_write  = 1'b1;
            end
            op_jal: begin
                src_a_sel = src_a_pc;
                wb_sel    = wb_snpc;
                rd_write  = 1'b1;
                is_jal    = 1'b1;
            end
            op_jalr: begin
                wb_sel   = wb_snpc; // target is rs1 + imm
                rd_write = 1'b1;
                is_jalr  = 1'b1;
            end
            op_branch: begin
                src_a_sel = src_a_pc;
                case (inst.b.funct3)
                    f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: is_branch = 1'b1;
                    default: illegal = 1'b1; // 010 and 011 are reserved
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                     reset,
    input  logic [alu_pkg::xlen-1:0] rs1_data,
    input  logic [alu_pkg::xlen-1:0] rs2_data,
    input  logic [alu_pkg::xlen-1:0] pc,
    input  logic [alu_pkg::xlen-1:0] snpc,
    input  isa_pkg::reg_addr_t       rd,
    input  logic [alu_pkg::xlen-1:0] imm,
    input  alu_pkg::alu_op_t         alu_op,
    input  alu_pkg::src_a_sel_t      src_a_sel,
    input  alu_pkg::src_b_sel_t      src_b_sel,
    input  alu_pkg::wb_sel_t         wb_sel,
    input  logic                     rd_write,
    input  logic                     is_branch,
    input  logic                     is_jal,
    input  logic                     is_jalr,
    input  logic [2:0]               branch_funct,
    output logic                     wb_en,
    output logic [alu_pkg::xlen-1:0] wb_data,
    output logic                     redirect,
    output logic [alu_pkg::xlen-1:0] redirect_pc
);
    import isa_pkg::*;
    import alu_pkg::*;

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            taken;

    always_comb begin
        case (src_a_sel)
            src_a_pc:   alu_a = pc;
            src_a_zero: alu_a = '0;
            default:    alu_a = rs1_data;
        endcase
    end

    assign alu_b = (src_b_sel == src_b_reg) ? rs2_data : imm;

    alu alu_inst (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result)
    );

    // compare runs beside the alu, which forms pc + imm
    always_comb begin
        case (branch_funct)
            f3_beq:  taken = (rs1_data == rs2_data);
            f3_bne:  taken = (rs1_data != rs2_data);
            f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: taken = (rs1_data < rs2_data);
            f3_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = is_jal | is_jalr | (is_branch & taken);
    assign redirect_pc = is_jalr ? {alu_result[xlen-1:1], 1'b0} : alu_result;

    assign wb_data = (wb_sel == wb_snpc) ? snpc : alu_result;
    assign wb_en   = rd_write && (rd != '0) && !reset; // x0 writes dropped here

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 of the alu group
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl or sra by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_u,
        fmt_j,
        fmt_b,
        fmt_none
    } inst_fmt_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, five ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

endpackage

//--- design/pc_unit.sv
`timescale 1ns/1ns

module pc_unit #(
    parameter logic [alu_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect,
    input  logic [alu_pkg::xlen-1:0] redirect_pc,
    output logic [alu_pkg::xlen-1:0] pc,
    output logic [alu_pkg::xlen-1:0] snpc
);

    assign snpc = pc + 32'd4; // sequential address

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc; // taken branch or jump
        end else begin
            pc <= snpc;
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                     clk,
    input  logic                     we,
    input  isa_pkg::reg_addr_t       waddr,
    input  logic [alu_pkg::xlen-1:0] wdata,
    input  isa_pkg::reg_addr_t       raddr1,
    input  isa_pkg::reg_addr_t       raddr2,
    output logic [alu_pkg::xlen-1:0] rdata1,
    output logic [alu_pkg::xlen-1:0] rdata2
);
    import alu_pkg::*;

    logic [xlen-1:0] regs [32];

    // we never arrives with waddr 0
    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hard-wired
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        inst,
    output logic [31:0]        pc,
    output logic               wb_en,
    output isa_pkg::reg_addr_t wb_rd,
    output logic [31:0]        wb_data,
    output logic               illegal
);
    import isa_pkg::*;
    import alu_pkg::*;

    logic [xlen-1:0] snpc;
    logic [xlen-1:0] redirect_pc;
    logic            redirect;

    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    alu_op_t         alu_op;
    src_a_sel_t      src_a_sel;
    src_b_sel_t      src_b_sel;
    wb_sel_t         wb_sel;
    logic            rd_write;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [2:0]      branch_funct;

    pc_unit #(
        .reset_pc(reset_pc)
    ) pc_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .pc         (pc),
        .snpc       (snpc)
    );

    decoder decoder_inst (
        .inst        (inst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (wb_rd), // destination goes straight out
        .imm         (imm),
        .alu_op      (alu_op),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .wb_sel      (wb_sel),
        .rd_write    (rd_write),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .branch_funct(branch_funct),
        .illegal     (illegal)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .we    (wb_en),
        .waddr (wb_rd),
        .wdata (wb_data),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    exec_unit exec_unit_inst (
        .reset       (reset),
        .rs1_data    (rdata1),
        .rs2_data    (rdata2),
        .pc          (pc),
        .snpc        (snpc),
        .rd          (wb_rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .wb_sel      (wb_sel),
        .rd_write    (rd_write),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .branch_funct(branch_funct),
        .wb_en       (wb_en),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

//--- verif/rv_core_assertions.sv
`timescale 1ns/1ns

module rv_core_assertions #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input logic               clk,
    input logic               reset,
    input logic [31:0]        pc,
    input logic               wb_en,
    input isa_pkg::reg_addr_t wb_rd,
    input logic               illegal
);

    int fail_count = 0; // failures seen so far

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset) wb_en |-> wb_rd != '0)
        else begin
            fail_count = fail_count + 1;
            $error("write enabled with x0 as target");
        end

    illegal_no_write: assert property (@(posedge clk) illegal |-> !wb_en)
        else begin
            fail_count = fail_count + 1;
            $error("illegal instruction writes a register");
        end

    pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else begin
            fail_count = fail_count + 1;
            $error("pc bit 0 is set");
        end

    // first cycle out of reset starts at the reset vector
    pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == reset_pc)
        else begin
            fail_count = fail_count + 1;
            $error("pc differs from reset_pc after reset");
        end

endmodule

bind rv_core rv_core_assertions #(.reset_pc(reset_pc)) rv_core_assertions_inst (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .wb_en  (wb_en),
    .wb_rd  (wb_rd),
    .illegal(illegal)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;
    import isa_pkg::*;

    localparam logic [31:0] start_pc    = 32'h8000_0000;
    localparam int          reset_len   = 8;
    localparam int          num_random  = 2000;
    localparam int          cycle_limit = reset_len + 31 + num_random + 61;

    logic               clk;
    logic               reset;
    logic [31:0]        inst;
    logic [31:0]        pc;
    logic               wb_en;
    reg_addr_t          wb_rd;
    logic [31:0]        wb_data;
    logic               illegal;

    logic [31:0] lfsr = 32'h4690_610e;
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    int          cycles = 0;

    rv_core #(.reset_pc(start_pc)) rv_core_inst (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .pc     (pc),
        .wb_en  (wb_en),
        .wb_rd  (wb_rd),
        .wb_data(wb_data),
        .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // stop at the first failing bound assertion
    always @(negedge clk) begin
        if (rv_core_inst.rv_core_assertions_inst.fail_count != 0) begin
            $display("a bound assertion failed, see the error above");
            $display("Something failed");
            $fatal(1, "assertion failure");
        end
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'b0, $signed(x) < $signed(y)};
            3'b011:  return {31'b0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic rv_inst_u random_inst();
        rv_inst_u    w;
        logic [31:0] pick;
        logic [31:0] alt;
        w = take_bits(25) << 7;
        pick = take_bits(3);
        alt = take_bits(1);
        case (pick[2:0])
            3'd0: w.r.opcode = op_reg;
            3'd1: w.r.opcode = op_imm;
            3'd2: w.r.opcode = op_lui;
            3'd3: w.r.opcode = op_auipc;
            3'd4: w.r.opcode = op_jal;
            3'd5: w.r.opcode = op_jalr;
            3'd6: w.r.opcode = op_branch;
            default: begin
                pick = take_bits(2);
                case (pick[1:0]) // load, store, fence, system
                    2'd0:    w.r.opcode = 7'b0000011;
                    2'd1:    w.r.opcode = 7'b0100011;
                    2'd2:    w.r.opcode = 7'b0001111;
                    default: w.r.opcode = 7'b1110011;
                endcase
            end
        endcase
        if (w.r.opcode == op_reg)
            w.r.funct7 = {1'b0, alt[0], 5'b0};
        if (w.r.opcode == op_imm && w.i.funct3 == 3'b001)
            w.i.imm[11:5] = 7'b0;
        if (w.r.opcode == op_imm && w.i.funct3 == 3'b101)
            w.i.imm[11:5] = {1'b0, alt[0], 5'b0};
        if (w.r.opcode == op_jalr)
            w.i.funct3 = 3'b000;
        return w;
    endfunction

    // drive one word, compare against the ISA model, then retire it
    task automatic run_inst(input rv_inst_u w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [31:0] next_pc;
        logic        writes;
        logic        ill;
        logic        taken;
        logic        exp_wb_en;
        inst = w;
        #10;
        a = model_regs[w.r.rs1];
        b = model_regs[w.r.rs2];
        data = '0;
        writes = 1'b0;
        ill = 1'b0;
        taken = 1'b0;
        next_pc = model_pc + 32'd4;
        case (w.r.opcode)
            op_reg: begin
                writes = 1'b1;
                data = ref_alu(w.r.funct3, w.r.funct7[5], a, b);
            end
            op_imm: begin
                writes = 1'b1;
                data = ref_alu(w.i.funct3, w.i.funct3 == 3'b101 && w.i.imm[10], a,
                               {{20{w.i.imm[11]}}, w.i.imm});
            end
            op_lui: begin
                writes = 1'b1;
                data = {w.u.imm_31_12, 12'b0};
            end
            op_auipc: begin
                writes = 1'b1;
                data = model_pc + {w.u.imm_31_12, 12'b0};
            end
            op_jal: begin
                writes = 1'b1;
                data = model_pc + 32'd4;
                next_pc = model_pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11,
                                      w.j.imm_10_1, 1'b0};
            end
            op_jalr: begin
                writes = 1'b1;
                data = model_pc + 32'd4;
                next_pc = (a + {{20{w.i.imm[11]}}, w.i.imm}) & ~32'd1;
            end
            op_branch: begin
                case (w.b.funct3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: ill = 1'b1;
                endcase
                if (taken)
                    next_pc = model_pc + {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5,
                                          w.b.imm_4_1, 1'b0};
            end
            default: ill = 1'b1;
        endcase
        exp_wb_en = writes && (w.r.rd != 5'd0);
        check_value(pc, model_pc, "pc");
        check_value(illegal, ill, "illegal");
        check_value(wb_en, exp_wb_en, "wb_en");
        if (exp_wb_en) begin
            check_value(wb_rd, w.r.rd, "wb_rd");
            check_value(wb_data, data, "wb_data");
            model_regs[w.r.rd] = data;
        end
        model_pc = next_pc;
        @(negedge clk);
    endtask

    initial begin
        rv_inst_u w;
        reset = 1'b1;
        inst = 32'h0010_0093; // addi x1, x0, 1
        model_pc = start_pc;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (reset_len) begin
            @(posedge clk);
            #5;
            check_value(wb_en, 1'b0, "wb_en during reset");
        end
        @(negedge clk);
        reset = 1'b0;
        for (int r = 1; r < 32; r++) begin
            w = '0;
            w.i.opcode = op_imm;
            w.i.rd = reg_addr_t'(r);
            w.i.funct3 = 3'b000;
            w.i.imm = 12'(take_bits(12));
            run_inst(w);
        end
        repeat (num_random) begin
            run_inst(random_inst());
        end
        if (rv_core_inst.rv_core_assertions_inst.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("assertion failures: %0d", rv_core_inst.rv_core_assertions_inst.fail_count);
            $display("Something failed");
            $fatal(1, "assertion failure");
        end
    end

endmodule

//--- vlog.f
design/isa_pkg.sv
design/alu_pkg.sv
design/alu.sv
design/reg_file.sv
design/pc_unit.sv
design/decoder.sv
design/exec_unit.sv
design/rv_core.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv
